/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module fetch_tb -Mdir obj_dir \
  || { echo "verilator build failed"; exit 1; }
./obj_dir/Vfetch_tb > sim.log 2>&1
grep -q "Simulation failed" sim.log && { echo "failure reported, see sim.log"; exit 1; }
grep -q "Simulation passed" sim.log || { echo "no pass line in sim.log"; exit 1; }
echo "run clean, log in sim.log"

/* sim.f */
+incdir+verilog
verilog/core_types_pkg.sv
verilog/wb_bus_pkg.sv
verilog/pc_sequencer.sv
verilog/wb_arbiter.sv
verilog/wb_word_memory.sv
verilog/fetch_subsystem_top.sv
verif/fetch_properties.sv
verif/fetch_tb.sv

/* verif/fetch_properties.sv */
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module fetch_properties (
  input logic                  clk,
  input logic                  rst_n,
  input wb_bus_pkg::wb_req_t   mem_req,
  input wb_bus_pkg::wb_rsp_t   mem_rsp,
  input core_types_pkg::inst_t inst_o,
  input logic                  inst_valid_o
);

  // slave only answers an open strobe
  ack_needs_stb: assert property (@(posedge clk) disable iff (!rst_n)
    mem_rsp.ack |-> mem_req.stb)
    else $error("memory ack without stb");

  // single cycle ack, never back to back
  ack_single: assert property (@(posedge clk) disable iff (!rst_n)
    mem_rsp.ack |=> !mem_rsp.ack)
    else $error("memory ack in two consecutive cycles");

  // master holds its request until ack
  req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_req.stb && !mem_rsp.ack) |=> $stable(mem_req))
    else $error("request changed while waiting for ack");

  // bubble shows as nop
  nop_when_invalid: assert property (@(posedge clk) disable iff (!rst_n)
    !inst_valid_o |-> (inst_o == `NOP_INST))
    else $error("inst_o not nop while invalid");

endmodule

bind fetch_subsystem_top fetch_properties u_fetch_properties (
  .clk          (clk),
  .rst_n        (rst_n),
  .mem_req      (mem_req),
  .mem_rsp      (mem_rsp),
  .inst_o       (inst_o),
  .inst_valid_o (inst_valid_o)
);

/* verif/fetch_tb.sv */
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module fetch_tb;

  logic                  clk;
  logic                  rst_n;
  logic                  stall_i;
  logic                  redirect_i;
  core_types_pkg::addr_t redirect_pc_i;
  wb_bus_pkg::wb_req_t   data_req;
  wb_bus_pkg::wb_rsp_t   data_rsp;
  core_types_pkg::inst_t inst_o;
  core_types_pkg::addr_t pc_o;
  logic                  inst_valid_o;

  // reference memory, with a flag for words the test has written
  logic [31:0]           ref_mem [`MEM_WORDS];
  bit                    ref_known [`MEM_WORDS];
  core_types_pkg::addr_t exp_pc;
  int unsigned           accepted;
  int unsigned           cycles;
  int unsigned           cycle_limit;
  logic [31:0]           rng;
  // stall hold tracking from the previous negedge
  logic                  hold_q;
  logic [31:0]           hold_pc;
  logic [31:0]           hold_inst;
  string                 lines[$];

  fetch_subsystem_top DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall_i       (stall_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .data_req_i    (data_req),
    .data_rsp_o    (data_rsp),
    .inst_o        (inst_o),
    .pc_o          (pc_o),
    .inst_valid_o  (inst_valid_o)
  );

  always #5 clk = ~clk;

  task automatic stop_with_fail();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s: got %h expected %h", $time, msg, got, exp);
      stop_with_fail();
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int unsigned word_index(input logic [31:0] addr);
    return (addr >> 2) % `MEM_WORDS;
  endfunction

  // run limit and hang guard
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run took more than %0d cycles", cycle_limit);
      stop_with_fail();
    end
  end

  // fetch stream monitor, sampled mid-cycle where outputs are settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (hold_q) begin
        check({31'b0, inst_valid_o}, 32'd1, "valid dropped during stall");
        check(pc_o, hold_pc, "pc changed during stall");
        check(inst_o, hold_inst, "inst changed during stall");
      end
      if (redirect_i) begin
        exp_pc = redirect_pc_i;
      end else if (inst_valid_o && !stall_i) begin
        // instruction taken at the coming edge
        check(pc_o, exp_pc, "fetch pc");
        if (ref_known[word_index(exp_pc)]) begin
          check(inst_o, ref_mem[word_index(exp_pc)], "fetched instruction");
        end
        exp_pc   = exp_pc + 4;
        accepted = accepted + 1;
      end
      hold_q    = inst_valid_o && stall_i && !redirect_i;
      hold_pc   = pc_o;
      hold_inst = inst_o;
    end
  end

  // one data port access, ack waited for on the negedge
  task automatic data_access(input logic we, input logic [31:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    @(posedge clk);
    #1;
    data_req.cyc   = 1'b1;
    data_req.stb   = 1'b1;
    data_req.we    = we;
    data_req.addr  = addr;
    data_req.wdata = wdata;
    do begin
      @(negedge clk);
    end while (!data_rsp.ack);
    rdata = data_rsp.rdata;
    // cyc drops the cycle after ack
    @(posedge clk);
    #1;
    data_req = '0;
  endtask

  task automatic redirect_to(input logic [31:0] target);
    @(posedge clk);
    #1;
    redirect_i    = 1'b1;
    redirect_pc_i = target;
    @(posedge clk);
    #1;
    redirect_i = 1'b0;
  endtask

  task automatic stall_for(input int unsigned n);
    @(posedge clk);
    #1;
    stall_i = 1'b1;
    repeat (n) @(posedge clk);
    #1;
    stall_i = 1'b0;
  endtask

  // take n instructions, optionally with random stall cycles
  task automatic fetch_run(input int unsigned n, input bit rand_stall);
    int unsigned target;
    target = accepted + n;
    @(posedge clk);
    #1;
    stall_i = 1'b0;
    while (accepted < target) begin
      @(posedge clk);
      #1;
      if (rand_stall) begin
        rng     = xorshift32(rng);
        stall_i = (rng[1:0] == 2'b00);
      end
    end
    stall_i = 1'b0;
  endtask

  task automatic run_line(input string line);
    byte         cmd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] rd;
    int          n;
    a   = '0;
    b   = '0;
    cmd = line.getc(0);
    n   = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
    case (cmd)
      "W": begin
        ref_mem[word_index(a)]   = b;
        ref_known[word_index(a)] = 1'b1;
        data_access(1'b1, a, b, rd);
      end
      "R": begin
        data_access(1'b0, a, '0, rd);
        check(rd, b, "data port load");
      end
      "F": fetch_run(a, (n > 1) && (b != 0));
      "J": redirect_to(a);
      "S": stall_for(a);
      default: begin
        $display("unknown command in test data file: %s", line);
        stop_with_fail();
      end
    endcase
  endtask

  initial begin
    int    fd;
    string line;
    clk           = 1'b0;
    rst_n         = 1'b0;
    stall_i       = 1'b1;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    data_req      = '0;
    exp_pc        = `RESET_PC;
    accepted      = 0;
    cycles        = 0;
    cycle_limit   = 100000;
    rng           = 32'd12595;
    hold_q        = 1'b0;
    hold_pc       = '0;
    hold_inst     = '0;
    foreach (ref_known[i]) ref_known[i] = 1'b0;

    fd = $fopen("verif/fetch_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open the test data file");
      stop_with_fail();
    end
    while ($fgets(line, fd) != 0) begin
      lines.push_back(line);
    end
    $fclose(fd);
    // twenty cycles per file line plus reset
    cycle_limit = 20 * lines.size() + 4;

    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check({31'b0, inst_valid_o}, 32'd0, "valid right after reset");
    check(inst_o, `NOP_INST, "nop right after reset");

    foreach (lines[i]) begin
      // skip comments and blank lines
      if (lines[i].len() > 0 && lines[i].getc(0) != "#" &&
          lines[i].getc(0) != "\n" && lines[i].getc(0) != " ") begin
        run_line(lines[i]);
      end
    end

    // let the stream settle before the verdict
    stall_for(2);
    $display("Simulation passed");
    $finish;
  end

endmodule

/* verif/fetch_testdata.txt */
# cmd a b : W addr data store, R addr expect load, J target redirect
# F count [rand] accept instructions, S cycles stall
W 00000000 00000093
W 00000004 00100113
W 00000008 00208193
W 0000000c 00310233
W 00000010 004182b3
W 00000014 00520333
W 00000018 006283b3
W 0000001c 00730433
W 00000020 008384b3
W 00000024 00940533
W 00000028 00a485b3
W 0000002c 00b50633
R 00000004 00100113
R 0000002c 00b50633
J 00000000
F 6
S 5
F 3
J 00000010
F 4
W 00000800 cafef00d
R 00000800 cafef00d
W 00000804 12345678
R 00000804 12345678
R 00000018 006283b3
J 00000000
F 40 1
S 3
R 00000800 cafef00d

/* verilog/core_types_pkg.sv */
`include "fetch_cfg.svh"

package core_types_pkg;

  // byte address
  typedef logic [`XLEN-1:0] addr_t;

  // one rv32 instruction, always 32 bits
  typedef logic [31:0] inst_t;

  // data word as moved over the bus
  typedef logic [`XLEN-1:0] word_t;

  // fetch sequencer states
  // IDLE  no bus cycle open, output empty or being taken
  // REQ   bus cycle open, waiting for ack
  // HOLD  output occupied and downstream stalled
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    REQ  = 2'd1,
    HOLD = 2'd2
  } fetch_state_t;

endpackage

/* verilog/fetch_cfg.svh */
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// address and data width in bits
`define XLEN 32

// memory depth in 32-bit words
// only the low word-index bits of an address select a word
`define MEM_WORDS 1024

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// addi x0,x0,0
// shown on the fetch output when no instruction is valid
`define NOP_INST 32'h0000_0013

`endif

/* verilog/fetch_subsystem_top.sv */
`timescale 1ns/100ps

module fetch_subsystem_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  stall_i,
  input  logic                  redirect_i,
  input  core_types_pkg::addr_t redirect_pc_i,
  input  wb_bus_pkg::wb_req_t   data_req_i,
  output wb_bus_pkg::wb_rsp_t   data_rsp_o,
  output core_types_pkg::inst_t inst_o,
  output core_types_pkg::addr_t pc_o,
  output logic                  inst_valid_o
);

  // fetch master to arbiter
  wb_bus_pkg::wb_req_t fetch_req;
  wb_bus_pkg::wb_rsp_t fetch_rsp;

  // arbiter to memory
  wb_bus_pkg::wb_req_t mem_req;
  wb_bus_pkg::wb_rsp_t mem_rsp;

  pc_sequencer u_pc_sequencer (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall_i       (stall_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .fetch_req_o   (fetch_req),
    .fetch_rsp_i   (fetch_rsp),
    .inst_o        (inst_o),
    .pc_o          (pc_o),
    .inst_valid_o  (inst_valid_o)
  );

  // load/store port has priority
  wb_arbiter u_wb_arbiter (
    .clk         (clk),
    .rst_n       (rst_n),
    .data_req_i  (data_req_i),
    .fetch_req_i (fetch_req),
    .data_rsp_o  (data_rsp_o),
    .fetch_rsp_o (fetch_rsp),
    .mem_req_o   (mem_req),
    .mem_rsp_i   (mem_rsp)
  );

  wb_word_memory u_wb_word_memory (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_req_i (mem_req),
    .mem_rsp_o (mem_rsp)
  );

endmodule

/* verilog/pc_sequencer.sv */
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module pc_sequencer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  stall_i,
  input  logic                  redirect_i,
  input  core_types_pkg::addr_t redirect_pc_i,
  output wb_bus_pkg::wb_req_t   fetch_req_o,
  input  wb_bus_pkg::wb_rsp_t   fetch_rsp_i,
  output core_types_pkg::inst_t inst_o,
  output core_types_pkg::addr_t pc_o,
  output logic                  inst_valid_o
);

  core_types_pkg::fetch_state_t state_q, state_d;
  core_types_pkg::addr_t        next_pc_q, next_pc_d;
  core_types_pkg::addr_t        req_addr_q, req_addr_d;
  core_types_pkg::addr_t        pc_q;
  core_types_pkg::inst_t        inst_q;
  logic                         inst_valid_q, inst_valid_d;
  logic                         drop_q, drop_d;
  logic                         take_rsp;

  // next state, next pc and the response keep/drop decision
  always_comb begin
    state_d    = state_q;
    next_pc_d  = next_pc_q;
    req_addr_d = req_addr_q;
    drop_d     = drop_q;
    take_rsp   = 1'b0;
    // a redirect always wins for the next fetch address
    if (redirect_i) begin
      next_pc_d = redirect_pc_i;
    end
    case (state_q)
      core_types_pkg::REQ: begin
        if (fetch_rsp_i.ack) begin
          // response from the old path is thrown away
          take_rsp = ~drop_q & ~redirect_i;
          if (take_rsp) begin
            next_pc_d = req_addr_q + core_types_pkg::addr_t'(4);
          end
          drop_d  = 1'b0;
          // drop cyc the cycle after ack
          state_d = core_types_pkg::IDLE;
        end else if (redirect_i) begin
          // cycle must finish on the bus, remember to discard it
          drop_d = 1'b1;
        end
      end
      default: begin
        // IDLE or HOLD: issue unless output is full and stalled
        if (redirect_i || !(inst_valid_q && stall_i)) begin
          state_d    = core_types_pkg::REQ;
          req_addr_d = redirect_i ? redirect_pc_i : next_pc_q;
        end else begin
          state_d = core_types_pkg::HOLD;
        end
      end
    endcase
  end

  // output valid
  // cleared by redirect, set by a kept ack, held while stalled
  always_comb begin
    if (redirect_i) begin
      inst_valid_d = 1'b0;
    end else if (take_rsp) begin
      inst_valid_d = 1'b1;
    end else begin
      inst_valid_d = inst_valid_q & stall_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= core_types_pkg::IDLE;
      next_pc_q    <= `RESET_PC;
      req_addr_q   <= `RESET_PC;
      drop_q       <= 1'b0;
      inst_valid_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      next_pc_q    <= next_pc_d;
      req_addr_q   <= req_addr_d;
      drop_q       <= drop_d;
      inst_valid_q <= inst_valid_d;
    end
  end

  // instruction and its pc, latched on a kept ack
  always_ff @(posedge clk) begin
    if (take_rsp) begin
      inst_q <= fetch_rsp_i.rdata;
      pc_q   <= req_addr_q;
    end
  end

  // fetch is read only
  assign fetch_req_o.cyc   = (state_q == core_types_pkg::REQ);
  assign fetch_req_o.stb   = (state_q == core_types_pkg::REQ);
  assign fetch_req_o.we    = 1'b0;
  assign fetch_req_o.addr  = req_addr_q;
  assign fetch_req_o.wdata = '0;

  // bubble shows as nop
  assign inst_o       = inst_valid_q ? inst_q : `NOP_INST;
  assign pc_o         = pc_q;
  assign inst_valid_o = inst_valid_q;

endmodule

/* verilog/wb_arbiter.sv */
`timescale 1ns/100ps

module wb_arbiter (
  input  logic                clk,
  input  logic                rst_n,
  input  wb_bus_pkg::wb_req_t data_req_i,
  input  wb_bus_pkg::wb_req_t fetch_req_i,
  output wb_bus_pkg::wb_rsp_t data_rsp_o,
  output wb_bus_pkg::wb_rsp_t fetch_rsp_o,
  output wb_bus_pkg::wb_req_t mem_req_o,
  input  wb_bus_pkg::wb_rsp_t mem_rsp_i
);

  wb_bus_pkg::grant_t grant_q;
  wb_bus_pkg::grant_t pick;
  wb_bus_pkg::grant_t sel;

  // fixed priority, load/store ahead of fetch
  always_comb begin
    if (data_req_i.cyc) begin
      pick = wb_bus_pkg::GNT_DATA;
    end else if (fetch_req_i.cyc) begin
      pick = wb_bus_pkg::GNT_FETCH;
    end else begin
      pick = wb_bus_pkg::GNT_NONE;
    end
  end

  // grant register
  // only chosen while idle, dropped on the owner's ack
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grant_q <= wb_bus_pkg::GNT_NONE;
    end else if (grant_q == wb_bus_pkg::GNT_NONE) begin
      grant_q <= pick;
    end else if (mem_rsp_i.ack) begin
      grant_q <= wb_bus_pkg::GNT_NONE;
    end
  end

  // while idle the winner goes straight through
  // so the memory sees stb in the grant cycle
  assign sel = (grant_q == wb_bus_pkg::GNT_NONE) ? pick : grant_q;

  always_comb begin
    case (sel)
      wb_bus_pkg::GNT_DATA:  mem_req_o = data_req_i;
      wb_bus_pkg::GNT_FETCH: mem_req_o = fetch_req_i;
      default:               mem_req_o = '0;
    endcase
  end

  // ack back to the owner only
  // the loser sees no ack and keeps waiting
  assign data_rsp_o.ack    = mem_rsp_i.ack & (grant_q == wb_bus_pkg::GNT_DATA);
  assign data_rsp_o.rdata  = mem_rsp_i.rdata;
  assign fetch_rsp_o.ack   = mem_rsp_i.ack & (grant_q == wb_bus_pkg::GNT_FETCH);
  assign fetch_rsp_o.rdata = mem_rsp_i.rdata;

endmodule

/* verilog/wb_bus_pkg.sv */
package wb_bus_pkg;

  // wishbone classic request from a master
  // cyc and stb rise together and stay up until ack
  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    core_types_pkg::addr_t addr;
    core_types_pkg::word_t wdata;
  } wb_req_t;

  // slave response
  // rdata only meaningful on the ack cycle of a read
  typedef struct packed {
    logic                  ack;
    core_types_pkg::word_t rdata;
  } wb_rsp_t;

  // which master owns the memory
  typedef enum logic [1:0] {
    GNT_NONE  = 2'd0,
    GNT_DATA  = 2'd1,
    GNT_FETCH = 2'd2
  } grant_t;

endpackage

/* verilog/wb_word_memory.sv */
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module wb_word_memory (
  input  logic                clk,
  input  logic                rst_n,
  input  wb_bus_pkg::wb_req_t mem_req_i,
  output wb_bus_pkg::wb_rsp_t mem_rsp_o
);

  // word index width
  localparam int IDX_W = $clog2(`MEM_WORDS);

  core_types_pkg::word_t mem [`MEM_WORDS];
  core_types_pkg::word_t rdata_q;
  logic [IDX_W-1:0]      idx;
  logic                  accept;
  logic                  ack_q;

  // byte address to word index, low two bits ignored
  assign idx = mem_req_i.addr[IDX_W+1:2];

  // fresh strobe only
  // the cycle after an ack still has stb up and must not ack again
  assign accept = mem_req_i.cyc & mem_req_i.stb & ~ack_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= accept;
    end
  end

  // array and read data
  // a write lands by the ack cycle
  always_ff @(posedge clk) begin
    if (accept) begin
      if (mem_req_i.we) begin
        mem[idx] <= mem_req_i.wdata;
      end
      rdata_q <= mem[idx];
    end
  end

  assign mem_rsp_o.ack   = ack_q;
  assign mem_rsp_o.rdata = rdata_q;

endmodule
